//--- src.f
+incdir+test
logic/lagPkg.sv
logic/satAddSub.sv
logic/lagIndexFsm.sv
logic/lagFrameSequencer.sv
logic/lagEncoderTop.sv
test/lagEncoderTb.sv

//--- Bender.yml
package:
  name: lag_encoder

sources:
  - logic/lagPkg.sv
  - logic/satAddSub.sv
  - logic/lagIndexFsm.sv
  - logic/lagFrameSequencer.sv
  - logic/lagEncoderTop.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/lagEncoderTb.sv

//--- test/lagRefModel.svh
`ifndef LAG_REF_MODEL_SVH
`define LAG_REF_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Expected values for one G.729 frame
////////////////////////////////////////////////////////////////////////////

// Subframe one index, 1/3 resolution up to lag 85
function automatic int firstIndex(input int t0, input int frac);
	int index;
	if (t0 <= 85)
		index = 3 * t0 - 58 + frac;
	else
		index = t0 + 112;
	return index;
endfunction

// Search range start, kept inside 20..143 with a 10 lag window
function automatic int rangeStart(input int t0);
	int low;
	low = t0 - 5;
	if (low < 20)
		low = 20;
	// Window may not pass the top lag
	if (low + 9 > 143)
		low = 143 - 9;
	return low;
endfunction

// Last lag of the window
function automatic int rangeEnd(input int t0);
	return rangeStart(t0) + 9;
endfunction

// Odd parity over index bits 7..2
function automatic int indexParity(input int index);
	int count;
	int bitPos;
	count = 1;
	for (bitPos = 2; bitPos <= 7; bitPos++)
		count = count + ((index >> bitPos) & 1);
	return count % 2;
endfunction

// Subframe two, relative to the window start
function automatic int secondIndex(input int t0, input int frac, input int low);
	return 3 * (t0 - low) + 2 + frac;
endfunction

`endif

//--- test/lagEncoderTb.sv
`timescale 1ns/10ps

module lagEncoderTb;
	import lagPkg::*;

	`include "lagRefModel.svh"

	localparam int          CLK_PERIOD    = 40;
	localparam int          RESET_CYCLES  = 16;
	localparam int unsigned SEED          = 32'h3cfde047;
	localparam int          RANDOM_FRAMES = 200;

	// Directed frames, the idle window after the busy test, then random frames
	localparam int TOTAL_FRAMES = 35 + RANDOM_FRAMES;

	// Longest frame is about 21 cycles plus driving
	localparam int FRAME_CYCLES = 30;
	localparam int TIMEOUT_NS   = TOTAL_FRAMES * FRAME_CYCLES * CLK_PERIOD
		+ RESET_CYCLES * CLK_PERIOD;

	logic     clk;
	logic     reset;
	logic     start;
	word_t    t0First;
	word_t    fracFirst;
	word_t    t0Second;
	word_t    fracSecond;
	logic     busy;
	logic     frameDone;
	logic     p0Parity;
	p1Index_t p1Index;
	p2Index_t p2Index;
	word_t    t0Min;
	word_t    t0Max;

	lagEncoderTop u_lagEncoderTop
	(
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.t0First    (t0First),
		.fracFirst  (fracFirst),
		.t0Second   (t0Second),
		.fracSecond (fracSecond),
		.busy       (busy),
		.frameDone  (frameDone),
		.p0Parity   (p0Parity),
		.p1Index    (p1Index),
		.p2Index    (p2Index),
		.t0Min      (t0Min),
		.t0Max      (t0Max)
	);

	// 40 ns clock
	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string field, input logic signed [31:0] actual,
		input logic signed [31:0] expected);
		if (actual !== expected)
		begin
			$display("** Error at %0t: %s is %0d, expected %0d", $time, field, actual,
				expected);
			$display(">>> FAIL");
			$fatal(1, "Mismatch on %s", field);
		end
	endtask

	// Inputs and start on the falling edge, start high for one cycle
	task automatic sendFrame(input int t0F, input int fF, input int t0S, input int fS);
		@(negedge clk);
		t0First    = t0F;
		fracFirst  = fF;
		t0Second   = t0S;
		fracSecond = fS;
		start      = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// Leaves at the falling edge inside the frameDone cycle
	task automatic waitForFrameDone();
		while (frameDone !== 1'b1)
			@(negedge clk);
	endtask

	task automatic verifyFrame(input int t0F, input int fF, input int t0S, input int fS);
		int expFirst;
		int expMin;
		int expMax;
		expFirst = firstIndex(t0F, fF);
		expMin   = rangeStart(t0F);
		expMax   = rangeEnd(t0F);
		checkValue("busy", busy, 0);
		checkValue("p1Index", p1Index, expFirst);
		checkValue("p0Parity", p0Parity, indexParity(expFirst));
		checkValue("t0Min", t0Min, expMin);
		checkValue("t0Max", t0Max, expMax);
		checkValue("p2Index", p2Index, secondIndex(t0S, fS, expMin));
	endtask

	task automatic runFrame(input int t0F, input int fF, input int t0S, input int fS);
		sendFrame(t0F, fF, t0S, fS);
		waitForFrameDone();
		verifyFrame(t0F, fF, t0S, fS);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	// Nothing moves without a start
	task automatic resetStateCheck();
		repeat (3) @(negedge clk);
		checkValue("busy", busy, 0);
		checkValue("frameDone", frameDone, 0);
		checkValue("p1Index", p1Index, 0);
		checkValue("p0Parity", p0Parity, 0);
		checkValue("p2Index", p2Index, 0);
		checkValue("t0Min", t0Min, 0);
		checkValue("t0Max", t0Max, 0);
	endtask

	// Lags up to 85 with every fraction
	task automatic fractionalRegion();
		int lags [5] = '{20, 31, 57, 72, 85};
		int frac;
		for (int i = 0; i < 5; i++)
			for (frac = -1; frac <= 1; frac++)
				runFrame(lags[i], frac, rangeStart(lags[i]) + 4, 0);
	endtask

	task automatic integerRegion();
		int lags [5] = '{86, 97, 110, 125, 138};
		for (int i = 0; i < 5; i++)
		begin
			runFrame(lags[i], 0, lags[i], 1);
			// Window is T0-5 .. T0+4 away from the limits
			checkValue("p1Index", p1Index, lags[i] + 112);
			checkValue("t0Min", t0Min, lags[i] - 5);
			checkValue("t0Max", t0Max, lags[i] + 4);
		end
	endtask

	task automatic rangeClamping();
		int lowLags [3]  = '{20, 22, 24};
		int highLags [3] = '{139, 141, 143};
		for (int i = 0; i < 3; i++)
		begin
			runFrame(lowLags[i], 0, 25, -1);
			checkValue("t0Min", t0Min, 20);
			checkValue("t0Max", t0Max, 29);
		end
		// Top of the table slides the window down
		for (int i = 0; i < 3; i++)
		begin
			runFrame(highLags[i], 0, 140, 1);
			checkValue("t0Min", t0Min, 134);
			checkValue("t0Max", t0Max, 143);
		end
	endtask

	task automatic secondSubframe();
		int lags [6]  = '{55, 55, 64, 64, 64, 59};
		int fracs [6] = '{0, 1, -1, 0, 1, -1};
		int doneCount;
		// Window 55..64, both edges and the middle
		for (int i = 0; i < 6; i++)
			runFrame(60, 0, lags[i], fracs[i]);

		// Second start while busy must be dropped
		sendFrame(100, 0, 97, 1);
		checkValue("busy", busy, 1);
		t0First    = 30;
		fracFirst  = -1;
		t0Second   = 28;
		fracSecond = 1;
		start      = 1'b1;
		@(negedge clk);
		start = 1'b0;
		waitForFrameDone();
		verifyFrame(100, 0, 97, 1);

		// No second frameDone afterwards
		doneCount = 0;
		repeat (40)
		begin
			@(negedge clk);
			if (frameDone)
				doneCount++;
		end
		checkValue("extra frameDone", doneCount, 0);
		checkValue("busy", busy, 0);
	endtask

	task automatic randomFrames();
		int t0F;
		int fF;
		int t0S;
		int fS;
		int low;
		repeat (RANDOM_FRAMES)
		begin
			t0F = 20 + int'($urandom % 124);
			if (t0F <= 85)
				fF = int'($urandom % 3) - 1;
			else
				fF = 0;
			low = rangeStart(t0F);
			t0S = low + int'($urandom % 10);
			fS  = int'($urandom % 3) - 1;
			// A fraction of -1 would fall below the window
			if (t0S == low && fS < 0)
				fS = 0;
			runFrame(t0F, fF, t0S, fS);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int unsigned seedValue;
		$timeformat(-9, 0, " ns", 0);
		seedValue  = $urandom(SEED);
		reset      = 1'b1;
		start      = 1'b0;
		t0First    = '0;
		fracFirst  = '0;
		t0Second   = '0;
		fracSecond = '0;

		// Reset over 16 rising edges
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		resetStateCheck();
		fractionalRegion();
		integerRegion();
		rangeClamping();
		secondSubframe();
		randomFrames();

		$display(">>> PASS");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired: frameDone never came within the time limit");
		$display(">>> FAIL");
		$fatal(1, "Simulation timed out");
	end

endmodule

//--- logic/lagEncoderTop.sv
`timescale 1ns/10ps

module lagEncoderTop
(
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  lagPkg::word_t    t0First,
	input  lagPkg::word_t    fracFirst,
	input  lagPkg::word_t    t0Second,
	input  lagPkg::word_t    fracSecond,
	output logic             busy,
	output logic             frameDone,
	output logic             p0Parity,
	output lagPkg::p1Index_t p1Index,
	output lagPkg::p2Index_t p2Index,
	output lagPkg::word_t    t0Min,
	output lagPkg::word_t    t0Max
);
	import lagPkg::*;

	// Sequencer to FSM
	logic  fsmStart;
	logic  pitFlag;
	word_t subT0;
	word_t subFrac;

	// FSM results
	word_t subIndex;
	word_t rangeMin;
	word_t rangeMax;
	logic  subDone;

	// Shared saturating adder and subtractor
	word_t addA;
	word_t addB;
	word_t subA;
	word_t subB;
	word_t addSum;
	word_t subDiff;

	////////////////////////////////////////////////////////////////////////////
	// Instances
	////////////////////////////////////////////////////////////////////////////

	lagFrameSequencer u_lagFrameSequencer
	(
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.t0First    (t0First),
		.fracFirst  (fracFirst),
		.t0Second   (t0Second),
		.fracSecond (fracSecond),
		.subIndex   (subIndex),
		.rangeMin   (rangeMin),
		.rangeMax   (rangeMax),
		.subDone    (subDone),
		.fsmStart   (fsmStart),
		.pitFlag    (pitFlag),
		.subT0      (subT0),
		.subFrac    (subFrac),
		.busy       (busy),
		.frameDone  (frameDone),
		.p0Parity   (p0Parity),
		.p1Index    (p1Index),
		.p2Index    (p2Index),
		.t0Min      (t0Min),
		.t0Max      (t0Max)
	);

	// One lag FSM serves both subframes
	lagIndexFsm u_lagIndexFsm
	(
		.clk      (clk),
		.reset    (reset),
		.fsmStart (fsmStart),
		.pitFlag  (pitFlag),
		.subT0    (subT0),
		.subFrac  (subFrac),
		.addSum   (addSum),
		.subDiff  (subDiff),
		.addA     (addA),
		.addB     (addB),
		.subA     (subA),
		.subB     (subB),
		.subIndex (subIndex),
		.rangeMin (rangeMin),
		.rangeMax (rangeMax),
		.subDone  (subDone)
	);

	satAddSub u_satAddSub
	(
		.addA    (addA),
		.addB    (addB),
		.subA    (subA),
		.subB    (subB),
		.addSum  (addSum),
		.subDiff (subDiff)
	);

endmodule

//--- logic/lagFrameSequencer.sv
`timescale 1ns/10ps

module lagFrameSequencer
(
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  lagPkg::word_t    t0First,
	input  lagPkg::word_t    fracFirst,
	input  lagPkg::word_t    t0Second,
	input  lagPkg::word_t    fracSecond,
	input  lagPkg::word_t    subIndex,
	input  lagPkg::word_t    rangeMin,
	input  lagPkg::word_t    rangeMax,
	input  logic             subDone,
	output logic             fsmStart,
	output logic             pitFlag,
	output lagPkg::word_t    subT0,
	output lagPkg::word_t    subFrac,
	output logic             busy,
	output logic             frameDone,
	output logic             p0Parity,
	output lagPkg::p1Index_t p1Index,
	output lagPkg::p2Index_t p2Index,
	output lagPkg::word_t    t0Min,
	output lagPkg::word_t    t0Max
);
	import lagPkg::*;

	typedef enum logic [1:0]
	{
		stIdle,
		stFirst,
		stSecond
	} seqState_t;

	seqState_t state;

	// Second subframe lag, kept until subframe one ends
	word_t t0SecondReg;
	word_t fracSecondReg;

	logic accept;
	logic firstDone;
	logic firstParity;

	// Starts while busy are dropped
	assign accept    = (state == stIdle) && start;
	assign firstDone = (state == stFirst) && subDone;
	assign busy      = (state != stIdle);

	// 1 + popcount of bits 7..2, mod 2
	assign firstParity = ~^subIndex[7:2];

	////////////////////////////////////////////////////////////////////////////
	// Subframe operands
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			t0SecondReg   <= t0Second;
			fracSecondReg <= fracSecond;
			subT0         <= t0First;
			subFrac       <= fracFirst;
		end
		// Switch FSM operands to subframe two
		else if (firstDone)
		begin
			subT0   <= t0SecondReg;
			subFrac <= fracSecondReg;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Control and frame parameters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state     <= stIdle;
			fsmStart  <= 1'b0;
			pitFlag   <= 1'b0;
			frameDone <= 1'b0;
			p0Parity  <= 1'b0;
			p1Index   <= '0;
			p2Index   <= '0;
			t0Min     <= '0;
			t0Max     <= '0;
		end
		else
		begin
			// Strobes last one cycle
			fsmStart  <= 1'b0;
			frameDone <= 1'b0;

			unique case (state)
				stIdle:
				begin
					if (start)
					begin
						pitFlag  <= 1'b0;
						fsmStart <= 1'b1;
						state    <= stFirst;
					end
				end

				// Index, range and parity of subframe one
				stFirst:
				begin
					if (subDone)
					begin
						p1Index  <= subIndex[7:0];
						p0Parity <= firstParity;
						t0Min    <= rangeMin;
						t0Max    <= rangeMax;
						pitFlag  <= 1'b1;
						fsmStart <= 1'b1;
						state    <= stSecond;
					end
				end

				// Relative index is five bits wide
				stSecond:
				begin
					if (subDone)
					begin
						p2Index   <= subIndex[4:0];
						frameDone <= 1'b1;
						state     <= stIdle;
					end
				end

				default:
				begin
					state <= stIdle;
				end
			endcase
		end
	end

endmodule

//--- logic/lagIndexFsm.sv
`timescale 1ns/10ps

module lagIndexFsm
(
	input  logic          clk,
	input  logic          reset,
	input  logic          fsmStart,
	input  logic          pitFlag,
	input  lagPkg::word_t subT0,
	input  lagPkg::word_t subFrac,
	input  lagPkg::word_t addSum,
	input  lagPkg::word_t subDiff,
	output lagPkg::word_t addA,
	output lagPkg::word_t addB,
	output lagPkg::word_t subA,
	output lagPkg::word_t subB,
	output lagPkg::word_t subIndex,
	output lagPkg::word_t rangeMin,
	output lagPkg::word_t rangeMax,
	output logic          subDone
);
	import lagPkg::*;

	// One arithmetic step per state
	typedef enum logic [4:0]
	{
		stIdle,
		stCheck,
		stIntIndex,
		stFracDouble,
		stFracTriple,
		stFracOffset,
		stFracAdd,
		stRangeLow,
		stClampLow,
		stRangeHigh,
		stClampHigh,
		stRangeShift,
		stRelDiff,
		stRelDouble,
		stRelTriple,
		stRelOffset,
		stRelAdd,
		stDone
	} fsmState_t;

	fsmState_t state;
	fsmState_t nextState;

	// Latched subframe inputs
	word_t t0Reg;
	word_t fracReg;
	logic  flagReg;

	// Intermediate values between steps
	word_t acc;
	word_t temp;
	word_t nextAcc;
	word_t nextTemp;

	// Next values of the held results
	word_t nextIndex;
	word_t nextMin;
	word_t nextMax;

	logic accept;

	// New subframe only from idle
	assign accept = (state == stIdle) && fsmStart;

	// Done pulse for one cycle
	assign subDone = (state == stDone);

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= stIdle;
			flagReg  <= 1'b0;
			subIndex <= '0;
			rangeMin <= '0;
			rangeMax <= '0;
		end
		else
		begin
			state    <= nextState;
			subIndex <= nextIndex;
			rangeMin <= nextMin;
			rangeMax <= nextMax;
			if (accept)
				flagReg <= pitFlag;
		end
	end

	// Operand and scratch registers
	always_ff @(posedge clk)
	begin
		acc  <= nextAcc;
		temp <= nextTemp;
		if (accept)
		begin
			t0Reg   <= subT0;
			fracReg <= subFrac;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state and arithmetic unit operands
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		nextAcc   = acc;
		nextTemp  = temp;
		nextIndex = subIndex;
		nextMin   = rangeMin;
		nextMax   = rangeMax;
		addA      = '0;
		addB      = '0;
		subA      = '0;
		subB      = '0;

		unique case (state)
			stIdle:
			begin
				if (fsmStart)
					nextState = stCheck;
			end

			// Relative coding, or T0 <= 85 test
			stCheck:
			begin
				if (flagReg)
					nextState = stRelDiff;
				else
				begin
					subA = t0Reg;
					subB = LAG_FRAC_LIMIT;
					if (subDiff[15] || subDiff == '0)
						nextState = stFracDouble;
					else
						nextState = stIntIndex;
				end
			end

			// index = T0 + 112
			stIntIndex:
			begin
				addA      = t0Reg;
				addB      = LAG_INT_OFFSET;
				nextIndex = addSum;
				nextState = stRangeLow;
			end

			// 2*T0
			stFracDouble:
			begin
				addA      = t0Reg;
				addB      = t0Reg;
				nextTemp  = addSum;
				nextState = stFracTriple;
			end

			// 3*T0
			stFracTriple:
			begin
				addA      = temp;
				addB      = t0Reg;
				nextAcc   = addSum;
				nextState = stFracOffset;
			end

			stFracOffset:
			begin
				subA      = acc;
				subB      = LAG_FRAC_OFFSET;
				nextTemp  = subDiff;
				nextState = stFracAdd;
			end

			// Fraction last
			stFracAdd:
			begin
				addA      = temp;
				addB      = fracReg;
				nextIndex = addSum;
				nextState = stRangeLow;
			end

			// Range start, T0 - 5
			stRangeLow:
			begin
				subA      = t0Reg;
				subB      = LAG_RANGE_LOW;
				nextMin   = subDiff;
				nextState = stClampLow;
			end

			// Raise start to PIT_MIN when below
			stClampLow:
			begin
				subA = rangeMin;
				subB = PIT_MIN;
				if (subDiff[15])
					nextMin = PIT_MIN;
				nextState = stRangeHigh;
			end

			stRangeHigh:
			begin
				addA      = rangeMin;
				addB      = LAG_RANGE_SPAN;
				nextMax   = addSum;
				nextState = stClampHigh;
			end

			// Past PIT_MAX the whole range slides down
			stClampHigh:
			begin
				subA = rangeMax;
				subB = PIT_MAX;
				if (!subDiff[15] && subDiff != '0)
				begin
					nextMax   = PIT_MAX;
					nextState = stRangeShift;
				end
				else
					nextState = stDone;
			end

			// Start follows the clamped end
			stRangeShift:
			begin
				subA      = rangeMax;
				subB      = LAG_RANGE_SPAN;
				nextMin   = subDiff;
				nextState = stDone;
			end

			// Offset of T0 into the held range
			stRelDiff:
			begin
				subA      = t0Reg;
				subB      = rangeMin;
				nextAcc   = subDiff;
				nextState = stRelDouble;
			end

			stRelDouble:
			begin
				addA      = acc;
				addB      = acc;
				nextTemp  = addSum;
				nextState = stRelTriple;
			end

			stRelTriple:
			begin
				addA      = temp;
				addB      = acc;
				nextAcc   = addSum;
				nextState = stRelOffset;
			end

			stRelOffset:
			begin
				addA      = acc;
				addB      = LAG_REL_OFFSET;
				nextTemp  = addSum;
				nextState = stRelAdd;
			end

			stRelAdd:
			begin
				addA      = temp;
				addB      = fracReg;
				nextIndex = addSum;
				nextState = stDone;
			end

			stDone:
			begin
				nextState = stIdle;
			end

			default:
			begin
				nextState = stIdle;
			end
		endcase
	end

endmodule

//--- logic/satAddSub.sv
`timescale 1ns/10ps

module satAddSub
(
	input  lagPkg::word_t addA,
	input  lagPkg::word_t addB,
	input  lagPkg::word_t subA,
	input  lagPkg::word_t subB,
	output lagPkg::word_t addSum,
	output lagPkg::word_t subDiff
);
	import lagPkg::*;

	// Full precision results, one guard bit
	logic signed [16:0] addWide;
	logic signed [16:0] subWide;

	////////////////////////////////////////////////////////////////////////////
	// Saturation to the 16-bit range
	////////////////////////////////////////////////////////////////////////////

	// Clip a 17-bit value like the add and sub basic operators
	function automatic word_t saturate(input logic signed [16:0] wide);
		word_t result;
		// Guard bit and sign bit disagree on overflow
		if (wide[16] != wide[15])
		begin
			// Negative overflow goes to the most negative word
			if (wide[16])
				result = 16'sh8000;
			else
				result = 16'sh7fff;
		end
		else
			result = wide[15:0];
		return result;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	// Sign extend both operands before the add
	assign addWide = {addA[15], addA} + {addB[15], addB};

	// Same for the subtract
	assign subWide = {subA[15], subA} - {subB[15], subB};

	// Results go back to the FSM in the same cycle
	assign addSum  = saturate(addWide);
	assign subDiff = saturate(subWide);

endmodule

//--- logic/lagPkg.sv
package lagPkg;

	////////////////////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////////////////////

	// Signed 16-bit word for lags, fractions and operands
	typedef logic signed [15:0] word_t;

	// First subframe pitch index
	typedef logic [7:0] p1Index_t;

	// Second subframe relative index
	typedef logic [4:0] p2Index_t;

	////////////////////////////////////////////////////////////////////////////
	// G.729 pitch lag constants
	////////////////////////////////////////////////////////////////////////////

	// Pitch lag limits from the standard
	localparam word_t PIT_MIN = 16'sd20;
	localparam word_t PIT_MAX = 16'sd143;

	// Highest lag coded with 1/3 resolution
	localparam word_t LAG_FRAC_LIMIT = 16'sd85;

	// Offset removed from 3*T0 in the fractional index
	localparam word_t LAG_FRAC_OFFSET = 16'sd58;

	// Offset added to T0 in the integer index
	localparam word_t LAG_INT_OFFSET = 16'sd112;

	// T0 minus this gives the start of the search range
	localparam word_t LAG_RANGE_LOW = 16'sd5;

	// Distance from range start to range end
	localparam word_t LAG_RANGE_SPAN = 16'sd9;

	// Offset added in the relative index of subframe two
	localparam word_t LAG_REL_OFFSET = 16'sd2;

endpackage
